/* design/bus_pkg.sv */
/*
 * memory bus package
 * word and address widths, memory depth and acknowledge latency of the RAM
 */
`default_nettype none

package bus_pkg;

  // the RAM holds 2**addr_width words
  localparam int addr_width = 10;
  localparam int data_width = 32;
  localparam int mem_depth  = 1 << addr_width;

  // cycles from a new strobe seen by the RAM to its acknowledge
  localparam int ack_latency = 2;
  localparam int lat_width   = $clog2(ack_latency + 1);

endpackage

`default_nettype wire

/* design/pattern_gen.sv */
/*
 * pattern generator
 * address and data LFSR pair, stepped together whenever next is high
 */
`default_nettype none

module pattern_gen
  import bus_pkg::*, ramtest_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  next,
  output logic [addr_width-1:0] addr,
  output logic [data_width-1:0] data
);

  logic [addr_width-1:0] addr_lfsr;
  logic [data_width-1:0] data_lfsr;

  // right-shift Galois steps that apply the mask when the lsb drops out
  always_ff @(posedge clk) begin
    if (rst) begin
      addr_lfsr <= addr_seed;
      data_lfsr <= data_seed;
    end else if (next) begin
      addr_lfsr <= (addr_lfsr >> 1) ^ (addr_lfsr[0] ? addr_taps : '0);
      data_lfsr <= (data_lfsr >> 1) ^ (data_lfsr[0] ? data_taps : '0);
    end
  end

  assign addr = addr_lfsr;
  assign data = data_lfsr;

endmodule

`default_nettype wire

/* design/ram_bist_top.sv */
/*
 * RAM BIST top level
 * two pattern generators, the test sequencer and the RAM model
 */
`default_nettype none

module ram_bist_top
  import bus_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic [data_width-1:0] fault_mask,
  output logic                  test_ended,
  output logic                  test_error,
  // bus brought out for observation
  output logic                  mem_stb,
  output logic                  mem_we,
  output logic [addr_width-1:0] mem_addr,
  output logic [data_width-1:0] mem_wdata,
  output logic [data_width-1:0] mem_rdata,
  output logic                  mem_ack
);

  logic                  wr_next;
  logic                  rd_next;
  logic [addr_width-1:0] wr_addr;
  logic [data_width-1:0] wr_data;
  logic [addr_width-1:0] rd_addr;
  logic [data_width-1:0] rd_data;

  pattern_gen wr_gen (
    .clk  (clk),
    .rst  (rst),
    .next (wr_next),
    .addr (wr_addr),
    .data (wr_data)
  );

  // same sequence as wr_gen trailing behind it
  pattern_gen rd_gen (
    .clk  (clk),
    .rst  (rst),
    .next (rd_next),
    .addr (rd_addr),
    .data (rd_data)
  );

  ramtest_seq seq_i (
    .clk        (clk),
    .rst        (rst),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .wr_next    (wr_next),
    .rd_next    (rd_next),
    .mem_stb    (mem_stb),
    .mem_we     (mem_we),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_rdata  (mem_rdata),
    .mem_ack    (mem_ack),
    .test_ended (test_ended),
    .test_error (test_error)
  );

  sram_model ram_i (
    .clk        (clk),
    .rst        (rst),
    .mem_stb    (mem_stb),
    .mem_we     (mem_we),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_rdata  (mem_rdata),
    .mem_ack    (mem_ack),
    .fault_mask (fault_mask)
  );

endmodule

`default_nettype wire

/* design/ramtest_pkg.sv */
/*
 * RAM test package
 * access schedule of the sequencer and the LFSR seeds and feedback masks
 */
`default_nettype none

package ramtest_pkg;

  import bus_pkg::*;

  // idle timer cycle and the point where a new strobe is raised
  localparam int data_period = 17;
  localparam int data_phase  = 7;
  localparam int timer_width = $clog2(data_period);

  // test ends when the access counter is all ones (1023 accesses)
  localparam int count_width = 10;

  // 10-bit Galois mask for x^10 + x^7 + 1 with period 1023
  localparam logic [addr_width-1:0] addr_seed = 10'h3db;
  localparam logic [addr_width-1:0] addr_taps = 10'h240;

  localparam logic [data_width-1:0] data_seed = 32'h75377599;
  localparam logic [data_width-1:0] data_taps = 32'hd0000001;

endpackage

`default_nettype wire

/* design/ramtest_seq.sv */
/*
 * RAM test sequencer
 * issues three writes per read, checks read data and flags completion
 */
`default_nettype none

module ramtest_seq
  import bus_pkg::*, ramtest_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  // write-side and read-side pattern generators
  input  logic [addr_width-1:0] wr_addr,
  input  logic [data_width-1:0] wr_data,
  input  logic [addr_width-1:0] rd_addr,
  input  logic [data_width-1:0] rd_data,
  output logic                  wr_next,
  output logic                  rd_next,
  // memory bus
  output logic                  mem_stb,
  output logic                  mem_we,
  output logic [addr_width-1:0] mem_addr,
  output logic [data_width-1:0] mem_wdata,
  input  logic [data_width-1:0] mem_rdata,
  input  logic                  mem_ack,
  // status
  output logic                  test_ended,
  output logic                  test_error
);

  logic [timer_width-1:0] timer;
  logic [count_width-1:0] access_cnt;
  logic                   is_read;

  assign is_read = ~mem_we;

  always_ff @(posedge clk) begin
    if (rst) begin
      timer      <= '0;
      mem_stb    <= 1'b0;
      mem_we     <= 1'b0;
      access_cnt <= '0;
      test_error <= 1'b0;
    end else if (!test_ended) begin
      if (!mem_stb) begin
        // idle timer only runs between accesses
        if (timer == timer_width'(data_period - 1)) begin
          timer <= '0;
        end else begin
          timer <= timer + 1'b1;
        end
        if (timer == timer_width'(data_phase)) begin
          mem_stb <= 1'b1;
          // every fourth access is a read
          mem_we  <= ~&access_cnt[1:0];
        end
      end else if (mem_ack) begin
        mem_stb    <= 1'b0;
        mem_we     <= 1'b0;
        access_cnt <= access_cnt + 1'b1;
        // sticky until reset
        if (is_read && mem_rdata != rd_data) begin
          test_error <= 1'b1;
        end
      end
    end
  end

  // generators step on the acknowledge of their own access type
  assign wr_next = mem_ack & mem_we;
  assign rd_next = mem_ack & is_read;

  // fields stay steady while strobed as the generators only move on ack
  assign mem_addr  = mem_we ? wr_addr : rd_addr;
  assign mem_wdata = wr_data;

  assign test_ended = &access_cnt;

endmodule

`default_nettype wire

/* design/sram_model.sv */
/*
 * synchronous RAM model
 * fixed-latency acknowledge and a stuck-at-one fault mask on the read path
 */
`default_nettype none

module sram_model
  import bus_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  mem_stb,
  input  logic                  mem_we,
  input  logic [addr_width-1:0] mem_addr,
  input  logic [data_width-1:0] mem_wdata,
  output logic [data_width-1:0] mem_rdata,
  output logic                  mem_ack,
  input  logic [data_width-1:0] fault_mask
);

  logic [data_width-1:0] mem [mem_depth];
  logic                  busy;
  logic [lat_width-1:0]  lat_cnt;
  logic                  start;
  logic                  fire;

  // a strobe still high in its ack cycle belongs to the old access
  assign start = mem_stb & ~busy & ~mem_ack;
  assign fire  = busy & (lat_cnt == lat_width'(ack_latency - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      busy    <= 1'b0;
      lat_cnt <= '0;
      mem_ack <= 1'b0;
    end else begin
      mem_ack <= fire;
      if (start) begin
        busy    <= 1'b1;
        lat_cnt <= '0;
      end else if (fire) begin
        busy <= 1'b0;
      end else if (busy) begin
        lat_cnt <= lat_cnt + 1'b1;
      end
    end
  end

  // array access lines up with the acknowledge
  always_ff @(posedge clk) begin
    if (fire) begin
      if (mem_we) begin
        mem[mem_addr] <= mem_wdata;
      end
      mem_rdata <= mem[mem_addr] | fault_mask;
    end
  end

endmodule

`default_nettype wire

/* ram_bist.f */
design/bus_pkg.sv
design/ramtest_pkg.sv
design/pattern_gen.sv
design/ramtest_seq.sv
design/sram_model.sv
design/ram_bist_top.sv
test/ramtest_props.sv
test/ram_bist_tb.sv

/* run.sh */
#!/bin/sh
# build the RAM BIST testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module ram_bist_tb -f ram_bist.f -o ram_bist_sim

out=$(./obj_dir/ram_bist_sim) || true
echo "$out"

if echo "$out" | grep -qx "All tests passed"; then
  exit 0
else
  exit 1
fi

/* test/ram_bist_tb.sv */
/*
 * RAM BIST testbench
 * runs a table of fault masks and checks every bus acknowledge against LFSR models
 */
`default_nettype none

module ram_bist_tb
  import bus_pkg::*, ramtest_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int clk_period   = 40;
  localparam int reset_cycles = 5;
  localparam int n_scen       = 4;
  localparam int n_access     = (1 << count_width) - 1;
  localparam int exp_reads    = n_access / 4;
  localparam int exp_writes   = n_access - exp_reads;
  localparam longint timeout_ns = longint'(n_scen) * n_access
    * (data_period + ack_latency + 4) * clk_period + n_scen * 200 * clk_period;
  localparam logic [15:0] rand_seed = 16'd13227;
  localparam logic [15:0] rand_taps = 16'hb400;

  logic                  clk = 1'b0;
  logic                  rst;
  logic [data_width-1:0] fault_mask;
  logic                  test_ended;
  logic                  test_error;
  logic                  mem_stb;
  logic                  mem_we;
  logic [addr_width-1:0] mem_addr;
  logic [data_width-1:0] mem_wdata;
  logic [data_width-1:0] mem_rdata;
  logic                  mem_ack;

  // scenario table
  string                 scen_name [n_scen];
  logic [data_width-1:0] scen_mask [n_scen];
  logic                  scen_err  [n_scen];

  string                 cur_name;
  int                    error_count = 0;
  logic [15:0]           rand_state;

  // reference model of both generators
  logic [addr_width-1:0] wr_addr_m;
  logic [data_width-1:0] wr_data_m;
  logic [addr_width-1:0] rd_addr_m;
  logic [data_width-1:0] rd_data_m;
  int                    wr_count;
  int                    rd_count;
  logic                  mismatch_seen;
  logic                  flag_reported;
  logic                  exp_we;

  ram_bist_top ram_bist_top_i (
    .clk        (clk),
    .rst        (rst),
    .fault_mask (fault_mask),
    .test_ended (test_ended),
    .test_error (test_error),
    .mem_stb    (mem_stb),
    .mem_we     (mem_we),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_rdata  (mem_rdata),
    .mem_ack    (mem_ack)
  );

  always #(clk_period / 2) clk = ~clk;

  // right-shift Galois steps from the package seeds and masks
  function automatic logic [addr_width-1:0] step_addr(input logic [addr_width-1:0] a);
    return (a >> 1) ^ (a[0] ? addr_taps : '0);
  endfunction

  function automatic logic [data_width-1:0] step_data(input logic [data_width-1:0] d);
    return (d >> 1) ^ (d[0] ? data_taps : '0);
  endfunction

  function automatic logic [15:0] next_rand(input logic [15:0] s);
    return (s >> 1) ^ (s[0] ? rand_taps : '0);
  endfunction

  // one LFSR step per bit taken
  function automatic logic [4:0] take_rand_bits();
    logic [4:0] bits;
    bits = '0;
    for (int b = 0; b < 5; b++) begin
      rand_state = next_rand(rand_state);
      bits[b]    = rand_state[0];
    end
    return bits;
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("error %s %s: expected %h, actual %h", cur_name, what, expected, actual);
    error_count++;
  endtask

  task automatic build_table();
    logic [4:0] bit_idx;
    rand_state = rand_seed;
    bit_idx    = take_rand_bits();
    scen_name[0] = "clean";
    scen_mask[0] = '0;
    scen_err[0]  = 1'b0;
    scen_name[1] = "stuck_bit0";
    scen_mask[1] = data_width'(1);
    scen_err[1]  = 1'b1;
    scen_name[2] = "stuck_rand";
    scen_mask[2] = data_width'(1) << bit_idx;
    scen_err[2]  = 1'b1;
    scen_name[3] = "stuck_high";
    scen_mask[3] = data_width'(1) << (data_width - 1);
    scen_err[3]  = 1'b1;
  endtask

  // bus monitor sampled mid-cycle
  always @(negedge clk) begin
    if (rst) begin
      wr_addr_m     = addr_seed;
      wr_data_m     = data_seed;
      rd_addr_m     = addr_seed;
      rd_data_m     = data_seed;
      wr_count      = 0;
      rd_count      = 0;
      mismatch_seen = 1'b0;
      flag_reported = 1'b0;
    end else begin
      // error flag follows the first bad read by one cycle
      if (test_error !== mismatch_seen && !flag_reported) begin
        report_mismatch("test_error", 32'(mismatch_seen), 32'(test_error));
        flag_reported = 1'b1;
      end
      if (mem_ack === 1'b1) begin
        exp_we = ((wr_count + rd_count) % 4) != 3;
        if (mem_we !== exp_we) begin
          report_mismatch("access type", 32'(exp_we), 32'(mem_we));
        end
        if (mem_we) begin
          if (mem_addr !== wr_addr_m) begin
            report_mismatch("write addr", 32'(wr_addr_m), 32'(mem_addr));
          end
          if (mem_wdata !== wr_data_m) begin
            report_mismatch("write data", wr_data_m, mem_wdata);
          end
          wr_addr_m = step_addr(wr_addr_m);
          wr_data_m = step_data(wr_data_m);
          wr_count++;
        end else begin
          if (mem_addr !== rd_addr_m) begin
            report_mismatch("read addr", 32'(rd_addr_m), 32'(mem_addr));
          end
          if (mem_rdata !== (rd_data_m | fault_mask)) begin
            report_mismatch("read data", rd_data_m | fault_mask, mem_rdata);
          end
          if (mem_rdata !== rd_data_m) begin
            mismatch_seen = 1'b1;
          end
          rd_addr_m = step_addr(rd_addr_m);
          rd_data_m = step_data(rd_data_m);
          rd_count++;
        end
      end
    end
  end

  task automatic check_no_strobe(input int cycles);
    logic seen;
    seen = 1'b0;
    repeat (cycles) begin
      @(negedge clk);
      if (mem_stb !== 1'b0 && !seen) begin
        $display("error %s: a strobe was issued after the test had ended", cur_name);
        error_count++;
        seen = 1'b1;
      end
    end
  endtask

  task automatic run_scenario(input int idx);
    cur_name = scen_name[idx];
    @(posedge clk);
    rst        <= 1'b1;
    fault_mask <= scen_mask[idx];
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    while (test_ended !== 1'b1) @(negedge clk);
    if (wr_count != exp_writes) begin
      report_mismatch("write count", 32'(exp_writes), 32'(wr_count));
    end
    if (rd_count != exp_reads) begin
      report_mismatch("read count", 32'(exp_reads), 32'(rd_count));
    end
    check_no_strobe(2 * data_period + ack_latency);
    if (test_error !== scen_err[idx]) begin
      report_mismatch("final test_error", 32'(scen_err[idx]), 32'(test_error));
    end
  endtask

  initial begin
    rst        = 1'b1;
    fault_mask = '0;
    build_table();
    for (int i = 0; i < n_scen; i++) begin
      run_scenario(i);
    end
    $display("%0d scenarios run, %0d errors", n_scen, error_count);
    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // watchdog sized from the access count of all scenarios
  initial begin
    #(timeout_ns);
    $display("timeout: the test did not end within %0d ns", timeout_ns);
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

/* test/ramtest_props.sv */
/*
 * sequencer bus properties
 * strobe hold, acknowledge framing and sticky status flags
 */
`default_nettype none

module ramtest_props
  import bus_pkg::*;
(
  input logic                  clk,
  input logic                  rst,
  input logic                  mem_stb,
  input logic                  mem_we,
  input logic [addr_width-1:0] mem_addr,
  input logic [data_width-1:0] mem_wdata,
  input logic                  mem_ack,
  input logic                  test_ended,
  input logic                  test_error
);

  timeunit 1ns;
  timeprecision 100ps;

  // request and its fields hold until acknowledged
  stb_held: assert property (
    @(posedge clk) disable iff (rst)
    mem_stb && !mem_ack |=> mem_stb && $stable(mem_we) && $stable(mem_addr)
      && $stable(mem_wdata)
  ) else $error("strobe or its fields changed before the acknowledge");

  ack_in_stb: assert property (
    @(posedge clk) disable iff (rst)
    mem_ack |-> mem_stb
  ) else $error("acknowledge seen without a strobe");

  ended_sticky: assert property (
    @(posedge clk) disable iff (rst)
    test_ended |=> test_ended
  ) else $error("test_ended fell without reset");

  error_sticky: assert property (
    @(posedge clk) disable iff (rst)
    test_error |=> test_error
  ) else $error("test_error fell without reset");

endmodule

bind ramtest_seq ramtest_props props_i (
  .clk        (clk),
  .rst        (rst),
  .mem_stb    (mem_stb),
  .mem_we     (mem_we),
  .mem_addr   (mem_addr),
  .mem_wdata  (mem_wdata),
  .mem_ack    (mem_ack),
  .test_ended (test_ended),
  .test_error (test_error)
);

`default_nettype wire
